/* design/buffer_port_mux.sv */
`timescale 1ns/1ns

module buffer_port_mux (
    input  logic                                                            clk,
    input  logic                                                            reset,
    input  conv_router_pkg::lane_result_t [conv_router_pkg::NUM_LANES-1:0] results,
    input  logic                                                            last_in,
    output conv_router_pkg::lane_result_t [conv_router_pkg::NUM_LANES-1:0] lanes,
    output logic [conv_router_pkg::NUM_BUFS-1:0]                           rd_en,
    output conv_router_pkg::row_t [conv_router_pkg::NUM_BUFS-1:0]          rd_adr,
    output logic                                                            collision,
    output logic                                                            done
);

    import conv_router_pkg::*;

    logic [NUM_BUFS-1:0]              en_c;
    row_t [NUM_BUFS-1:0]              adr_c;
    logic [NUM_BUFS-1:0][CLAIM_W-1:0] claims;
    logic                             coll_c;

    ////////////////////////////////////////////////////////////
    // lane to buffer crossbar
    ////////////////////////////////////////////////////////////

    always_comb begin
        en_c   = '0;
        adr_c  = '0;
        claims = '0;
        coll_c = 1'b0;
        for (int b = 0; b < NUM_BUFS; b++) begin
            // top lane first so lane 0 is written last and wins
            for (int l = NUM_LANES - 1; l >= 0; l--) begin
                if (results[l].valid && !results[l].pad &&
                    (results[l].buf_idx == buf_idx_t'(b))) begin
                    en_c[b]   = 1'b1;
                    adr_c[b]  = results[l].buf_adr;
                    claims[b] = claims[b] + CLAIM_W'(1);
                end
            end
            // two lanes on one buffer port
            if (claims[b] > CLAIM_W'(1)) begin
                coll_c = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // output stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            lanes     <= '0;
            rd_en     <= '0;
            rd_adr    <= '0;
            collision <= 1'b0;
            done      <= 1'b0;
        end else begin
            // consumer steers lane data with these
            lanes     <= results;
            rd_en     <= en_c;
            rd_adr    <= adr_c;
            collision <= coll_c;
            done      <= last_in;
        end
    end

endmodule

/* design/conv_router_pkg.sv */
package conv_router_pkg;

    ////////////////////////////////////////////////////////////
    // widths and counts
    ////////////////////////////////////////////////////////////

    // row indices, feature map sizes and buffer addresses
    localparam int ROW_W = 16;
    // kernel size, stride and pad
    localparam int KER_W = 4;

    // output rows handled per tile, one per lane
    localparam int NUM_LANES = 3;
    // line buffers in the ring
    localparam int NUM_BUFS = 3;

    // signed input row, wide enough for row * stride + kernel row
    localparam int Y_W = ROW_W + KER_W + 2;

    // per-buffer claim counter, holds up to NUM_LANES
    localparam int CLAIM_W = $clog2(NUM_LANES + 1);

    ////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////

    typedef logic [ROW_W-1:0] row_t;
    typedef logic [KER_W-1:0] ker_t;
    typedef logic [1:0] buf_idx_t;
    typedef logic signed [Y_W-1:0] row_y_t;

    ////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////

    // job configuration, sampled on start
    typedef struct packed {
        ker_t k;
        ker_t s;
        ker_t p;
        row_t iy;
        row_t oy;
    } conv_cfg_t;

    // one walker step, broadcast to all lanes
    typedef struct packed {
        logic       step_valid;
        row_t       oy_start;
        ker_t       kr;
        logic [1:0] poy;
        logic       last;
    } row_step_t;

    // one lane's answer for a step
    typedef struct packed {
        logic     valid;
        logic     pad;
        buf_idx_t buf_idx;
        row_t     buf_adr;
    } lane_result_t;

    // walker FSM
    typedef enum logic {
        IDLE,
        RUN
    } walker_state_e;

endpackage

/* design/conv_row_router.sv */
`timescale 1ns/1ns

module conv_row_router (
    input  logic                                                            clk,
    input  logic                                                            reset,
    input  logic                                                            start,
    input  conv_router_pkg::conv_cfg_t                                      cfg,
    output logic                                                            busy,
    output conv_router_pkg::lane_result_t [conv_router_pkg::NUM_LANES-1:0] lanes,
    output logic [conv_router_pkg::NUM_BUFS-1:0]                           rd_en,
    output conv_router_pkg::row_t [conv_router_pkg::NUM_BUFS-1:0]          rd_adr,
    output logic                                                            collision,
    output logic                                                            done
);

    import conv_router_pkg::*;

    conv_cfg_t                    cfg_q;
    row_step_t                    step;
    lane_result_t [NUM_LANES-1:0] lane_res;
    logic [NUM_LANES-1:0]         lane_last;

    ////////////////////////////////////////////////////////////
    // tile and kernel row walk
    ////////////////////////////////////////////////////////////

    row_tile_walker i_row_tile_walker (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .cfg   (cfg),
        .cfg_q (cfg_q),
        .step  (step),
        .busy  (busy)
    );

    // one lane per output row of the tile
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        row_lane i_row_lane (
            .clk      (clk),
            .reset    (reset),
            .lane_id  (buf_idx_t'(l)),
            .step     (step),
            .cfg_q    (cfg_q),
            .result   (lane_res[l]),
            .last_out (lane_last[l])
        );
    end

    ////////////////////////////////////////////////////////////
    // buffer read ports
    ////////////////////////////////////////////////////////////

    // every lane carries the same last flag, lane 0 always exists
    buffer_port_mux i_buffer_port_mux (
        .clk       (clk),
        .reset     (reset),
        .results   (lane_res),
        .last_in   (lane_last[0]),
        .lanes     (lanes),
        .rd_en     (rd_en),
        .rd_adr    (rd_adr),
        .collision (collision),
        .done      (done)
    );

endmodule

/* design/row_lane.sv */
`timescale 1ns/1ns

module row_lane (
    input  logic                          clk,
    input  logic                          reset,
    input  conv_router_pkg::buf_idx_t     lane_id,
    input  conv_router_pkg::row_step_t    step,
    input  conv_router_pkg::conv_cfg_t    cfg_q,
    output conv_router_pkg::lane_result_t result,
    output logic                          last_out
);

    import conv_router_pkg::*;

    row_t   out_row;
    row_y_t y;
    row_t   y_row;
    logic   valid_c;
    logic   pad_c;
    logic   use_c;

    // output row owned by this lane within the tile
    assign out_row = step.oy_start + row_t'(lane_id);

    // input row for this kernel row, may fall above or below the image
    assign y = row_y_t'(out_row) * row_y_t'(cfg_q.s) + row_y_t'(step.kr)
               - row_y_t'(cfg_q.p);

    // lanes past poy sit idle in the final tile
    assign valid_c = step.step_valid && (lane_id < step.poy);

    // top or bottom padding
    assign pad_c = valid_c && ((y < 0) || (y >= row_y_t'(cfg_q.iy)));

    assign use_c = valid_c && !pad_c;

    // non-negative and below iy whenever it is used
    assign y_row = row_t'(y);

    ////////////////////////////////////////////////////////////
    // result stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            result   <= '0;
            last_out <= 1'b0;
        end else begin
            result.valid <= valid_c;
            result.pad   <= pad_c;
            // ring of three buffers, row y lives in buffer y mod 3
            result.buf_idx <= use_c ? buf_idx_t'(y_row % NUM_BUFS) : '0;
            result.buf_adr <= use_c ? row_t'(y_row / NUM_BUFS) : '0;
            // job end travels alongside the results
            last_out <= step.step_valid && step.last;
        end
    end

endmodule

/* design/row_tile_walker.sv */
`timescale 1ns/1ns

module row_tile_walker (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  conv_router_pkg::conv_cfg_t cfg,
    output conv_router_pkg::conv_cfg_t cfg_q,
    output conv_router_pkg::row_step_t step,
    output logic                       busy
);

    import conv_router_pkg::*;

    walker_state_e state;
    row_t          oy_cnt;
    ker_t          kr_cnt;
    row_t          rows_left;
    logic [1:0]    poy_c;
    logic          accept;
    logic          tile_last;
    logic          kr_last;
    logic          empty_job;
    logic          job_last;

    ////////////////////////////////////////////////////////////
    // tile bookkeeping
    ////////////////////////////////////////////////////////////

    // steps come back to back, so the step strobe is the busy flag
    assign busy = step.step_valid;

    // start only counts once the previous job has fully drained
    assign accept = (state == IDLE) && start && !busy;

    // output rows left from the current tile start
    assign rows_left = cfg_q.oy - oy_cnt;

    // partial last tile
    assign poy_c = (rows_left >= row_t'(NUM_LANES)) ? 2'(NUM_LANES) : rows_left[1:0];

    assign tile_last = (rows_left <= row_t'(NUM_LANES));
    assign kr_last   = ((kr_cnt + ker_t'(1)) == cfg_q.k);

    // nothing to walk, finish with a single empty step
    assign empty_job = (cfg_q.oy == '0) || (cfg_q.k == '0);
    assign job_last  = empty_job || (tile_last && kr_last);

    ////////////////////////////////////////////////////////////
    // FSM and counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            oy_cnt <= '0;
            kr_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state  <= RUN;
                        oy_cnt <= '0;
                        kr_cnt <= '0;
                    end
                end
                RUN: begin
                    if (job_last) begin
                        state <= IDLE;
                    end
                    // kernel rows inner, tiles outer
                    if (kr_last) begin
                        kr_cnt <= '0;
                        oy_cnt <= oy_cnt + row_t'(NUM_LANES);
                    end else begin
                        kr_cnt <= kr_cnt + ker_t'(1);
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // configuration held for the whole job
    always_ff @(posedge clk) begin
        if (accept) begin
            cfg_q <= cfg;
        end
    end

    ////////////////////////////////////////////////////////////
    // step register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= '0;
        end else begin
            step.step_valid <= (state == RUN);
            step.oy_start   <= oy_cnt;
            step.kr         <= kr_cnt;
            step.poy        <= empty_job ? 2'd0 : poy_c;
            step.last       <= (state == RUN) && job_last;
        end
    end

endmodule

/* dv/conv_row_router_assert.sv */
`timescale 1ns/1ns

module conv_row_router_assert (
    input logic                                                            clk,
    input logic                                                            reset,
    input logic                                                            busy,
    input conv_router_pkg::lane_result_t [conv_router_pkg::NUM_LANES-1:0] lanes,
    input logic [conv_router_pkg::NUM_BUFS-1:0]                           rd_en,
    input logic                                                            done
);

    import conv_router_pkg::*;

    logic pad_claim;

    // padded lanes that still name a buffer
    always_comb begin
        pad_claim = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (lanes[l].valid && lanes[l].pad &&
                (lanes[l].buf_idx != '0 || lanes[l].buf_adr != '0)) begin
                pad_claim = 1'b1;
            end
        end
    end

    done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done stayed high for more than one cycle");

    idle_no_read: assert property (@(posedge clk) disable iff (reset)
        (!busy && !$past(busy) && !$past(busy, 2)) |-> (rd_en == '0))
        else $error("rd_en set after the router went idle");

    pad_no_claim: assert property (@(posedge clk) disable iff (reset) !pad_claim)
        else $error("padded lane carries a buffer index or address");

endmodule

/* dv/conv_row_router_tb.sv */
`timescale 1ns/1ns

module conv_row_router_tb;

    import conv_router_pkg::*;

    localparam int NUM_TESTS    = 6;
    localparam int RESET_CYCLES = 10;
    localparam int TEST_MARGIN  = 10;
    localparam int FIRST_WAIT   = 8;
    localparam int EXP_LATENCY  = 3;
    localparam logic [31:0] SEED = 32'h0bab08c5;

    logic                         clk;
    logic                         reset;
    logic                         start;
    conv_cfg_t                    cfg;
    logic                         busy;
    lane_result_t [NUM_LANES-1:0] lanes;
    logic [NUM_BUFS-1:0]          rd_en;
    row_t [NUM_BUFS-1:0]          rd_adr;
    logic                         collision;
    logic                         done;

    // stimulus table with the expected step count and collision behavior
    conv_cfg_t cfg_tab [NUM_TESTS];
    int        steps_tab [NUM_TESTS];
    bit        coll_tab [NUM_TESTS];

    int errors = 0;
    int tests_failed = 0;
    int cycle = 0;
    int timeout_cycles = 0;

    conv_row_router i_conv_row_router (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .cfg       (cfg),
        .busy      (busy),
        .lanes     (lanes),
        .rd_en     (rd_en),
        .rd_adr    (rd_adr),
        .collision (collision),
        .done      (done)
    );

    bind conv_row_router conv_row_router_assert i_conv_row_router_assert (
        .clk       (clk),
        .reset     (reset),
        .busy      (busy),
        .lanes     (lanes),
        .rd_en     (rd_en),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("timeout after %0d cycles, a job never finished", cycle);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers and reference model
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic conv_cfg_t make_cfg(input int k, input int s, input int p,
                                           input int iy, input int oy);
        conv_cfg_t c;
        c.k  = ker_t'(k);
        c.s  = ker_t'(s);
        c.p  = ker_t'(p);
        c.iy = row_t'(iy);
        c.oy = row_t'(oy);
        return c;
    endfunction

    // ceil(oy / 3) tiles of k kernel rows
    function automatic int steps_for(input conv_cfg_t c);
        return ((int'(c.oy) + NUM_LANES - 1) / NUM_LANES) * int'(c.k);
    endfunction

    // lane l of step j, straight from the row mapping rules
    function automatic lane_result_t expected_lane(input conv_cfg_t c, input int j,
                                                   input int l);
        lane_result_t r;
        int           oy_start;
        int           kr;
        int           poy;
        int           y;
        r        = '0;
        oy_start = (j / int'(c.k)) * NUM_LANES;
        kr       = j % int'(c.k);
        poy      = int'(c.oy) - oy_start;
        if (poy > NUM_LANES) begin
            poy = NUM_LANES;
        end
        if (j < steps_for(c) && l < poy) begin
            r.valid = 1'b1;
            y = (oy_start + l) * int'(c.s) + kr - int'(c.p);
            if (y < 0 || y >= int'(c.iy)) begin
                r.pad = 1'b1;
            end else begin
                r.buf_idx = buf_idx_t'(y % NUM_BUFS);
                r.buf_adr = row_t'(y / NUM_BUFS);
            end
        end
        return r;
    endfunction

    task automatic load_table();
        int k;
        cfg_tab[0] = make_cfg(3, 1, 1, 8, 8);
        cfg_tab[1] = make_cfg(3, 2, 1, 16, 8);
        cfg_tab[2] = make_cfg(1, 1, 0, 5, 5);
        cfg_tab[3] = make_cfg(5, 1, 2, 7, 7);
        cfg_tab[4] = make_cfg(2, 3, 0, 20, 6);
        k = 1 + int'($urandom % 5);
        cfg_tab[5] = make_cfg(k, 1 + int'($urandom % 2), int'($urandom % k),
                              1 + int'($urandom % 24), 1 + int'($urandom % 12));
        steps_tab = '{9, 9, 2, 15, 4, 0};
        steps_tab[5] = ((int'(cfg_tab[5].oy) + 2) / 3) * k;
        // only stride 3 puts all lanes on one buffer
        coll_tab = '{0, 0, 0, 0, 1, 0};
    endtask

    // compare one cycle of outputs against step j
    task automatic check_step(input conv_cfg_t c, input int j, input bit exp_done);
        lane_result_t        el;
        logic [NUM_BUFS-1:0] en;
        row_t                adr [NUM_BUFS];
        int                  claims [NUM_BUFS];
        logic                coll;
        int                  b;
        en   = '0;
        coll = 1'b0;
        for (int i = 0; i < NUM_BUFS; i++) begin
            claims[i] = 0;
            adr[i]    = '0;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            el = expected_lane(c, j, l);
            check_value($sformatf("lanes[%0d]", l), 32'(el), 32'(lanes[l]));
            if (el.valid && !el.pad) begin
                b = int'(el.buf_idx);
                // lowest lane wins the port
                if (!en[b]) begin
                    adr[b] = el.buf_adr;
                end
                en[b] = 1'b1;
                claims[b]++;
            end
        end
        for (int i = 0; i < NUM_BUFS; i++) begin
            if (claims[i] > 1) begin
                coll = 1'b1;
            end
            if (en[i]) begin
                check_value($sformatf("rd_adr[%0d]", i), 32'(adr[i]), 32'(rd_adr[i]));
            end
        end
        check_value("rd_en", 32'(en), 32'(rd_en));
        check_value("collision", 32'(coll), 32'(collision));
        check_value("done", 32'(exp_done), 32'(done));
    endtask

    ////////////////////////////////////////////////////////////
    // one job from the table
    ////////////////////////////////////////////////////////////

    task automatic run_test(input int idx);
        conv_cfg_t            c;
        int                   n;
        int                   lat;
        int                   j;
        int                   err_before;
        bit                   seen;
        bit                   coll_seen;
        logic [NUM_LANES-1:0] vmask;
        c          = cfg_tab[idx];
        n          = steps_tab[idx];
        err_before = errors;
        seen       = 1'b0;
        coll_seen  = 1'b0;
        lat        = 0;
        j          = 0;
        @(posedge clk);
        start <= 1'b1;
        cfg   <= c;
        @(posedge clk);
        start <= 1'b0;
        // wait for the first result, a second start goes in while busy
        while (!seen && lat <= FIRST_WAIT) begin
            @(negedge clk);
            if (lanes[0].valid || done) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                lat++;
                if (lat == 1) begin
                    start <= 1'b1;
                    cfg   <= make_cfg(2, 3, 1, 4, 11);
                end else if (lat == 2) begin
                    start <= 1'b0;
                end
            end
        end
        if (!seen) begin
            $display("test %0d produced no output within %0d cycles", idx, FIRST_WAIT);
            errors++;
        end else begin
            check_value("first_output_latency", 32'(EXP_LATENCY), 32'(lat));
            check_value("busy", 32'(n >= 3), 32'(busy));
        end
        while (seen) begin
            check_step(c, j, j == n - 1);
            if (collision) begin
                coll_seen = 1'b1;
            end
            if (done || j >= n + 4) begin
                break;
            end
            @(posedge clk);
            start <= 1'b0;
            @(negedge clk);
            j++;
        end
        if (seen && !done) begin
            $display("test %0d never raised done", idx);
            errors++;
        end
        if (seen) begin
            check_value("step_count", 32'(n), 32'(j + 1));
            check_value("busy", 32'(0), 32'(busy));
            check_value("collision_seen", 32'(coll_tab[idx]), 32'(coll_seen));
        end
        // nothing may follow the last step
        @(posedge clk);
        @(negedge clk);
        for (int l = 0; l < NUM_LANES; l++) begin
            vmask[l] = lanes[l].valid;
        end
        check_value("lane_valid_after_done", 32'(0), 32'(vmask));
        check_value("rd_en_after_done", 32'(0), 32'(rd_en));
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("test %0d k=%0d s=%0d p=%0d iy=%0d oy=%0d steps=%0d: %s", idx, c.k, c.s,
                 c.p, c.iy, c.oy, n, (errors == err_before) ? "ok" : "FAIL");
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        start = 1'b0;
        cfg   = '0;
        void'($urandom(SEED));
        load_table();
        timeout_cycles = RESET_CYCLES;
        for (int i = 0; i < NUM_TESTS; i++) begin
            timeout_cycles += steps_tab[i] + TEST_MARGIN;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        $display("%0d tests, %0d ok, %0d with errors, %0d errors in total", NUM_TESTS,
                 NUM_TESTS - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the conv row router testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module conv_row_router_tb \
    -Mdir obj_dir \
    -f verilog.f \
    && ./obj_dir/Vconv_row_router_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log

# the log decides the result
grep -q "^Test passed$" sim.log \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }

exit 0

/* verilog.f */
design/conv_router_pkg.sv
design/row_tile_walker.sv
design/row_lane.sv
design/buffer_port_mux.sv
design/conv_row_router.sv
dv/conv_row_router_assert.sv
dv/conv_row_router_tb.sv
